// ==== include/frog_defines.svh ====
`ifndef FROG_DEFINES_SVH
`define FROG_DEFINES_SVH

// ##########################################################################
// grid geometry and player start.
// ##########################################################################

`define GRID_COLS       8
`define START_COL       1
`define START_ROW       5

// rows that carry traffic. row 0 is the goal row.
`define CAR_ROW         4
`define TRUCK_ROW       3
`define BIGTRUCK_ROW    1

// ##########################################################################
// lane timing and occupancy, one bit per column.
// ##########################################################################

`define CAR_PERIOD      4
`define TRUCK_PERIOD    8
`define BIGTRUCK_PERIOD 8

`define CAR_INIT        8'b0100_1001    // columns 0, 3 and 6.
`define TRUCK_INIT      8'b1101_1011    // columns 0, 1, 3, 4, 6 and 7.
`define BIGTRUCK_INIT   8'b1110_0111    // columns 0, 1, 2, 5, 6 and 7.

// bricks on row 0; the free columns 1, 4 and 7 are the goals.
`define BRICK_MASK      8'b0110_1101

`endif

// ==== design/frogPkg.sv ====
`default_nettype none

package frogPkg;

    // game progress, held by the judge.
    typedef enum logic [1:0] {
        MOVE,
        DIE,
        SUCCESS
    } gameState;

    typedef enum logic [1:0] {
        UP,
        LEFT,
        RIGHT
    } moveDir;

    typedef logic [2:0] cellCol;    // 0 is the leftmost column.
    typedef logic [2:0] cellRow;    // 0 is the goal row, 5 the start row.

    // bit i set means column i of the lane is occupied.
    typedef logic [7:0] laneOcc;

    // tens digit in the high nibble.
    typedef logic [7:0] bcdStep;

endpackage

`default_nettype wire

// ==== design/trafficLane.sv ====
`timescale 1ns/1ns
`default_nettype none

module trafficLane #(
    parameter int             PERIOD    = 4,
    parameter bit             MOVE_LEFT = 1'b0,
    parameter frogPkg::laneOcc INIT     = 8'h01
) (
    input  wire              CLK_05Hz,
    input  wire              RESET,
    input  frogPkg::gameState state,
    output frogPkg::laneOcc   occ
);
    import frogPkg::*;

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(PERIOD - 1);

    logic [CNT_W-1:0] cycleCnt;
    laneOcc           nextOcc;

    // moving left takes column i+1 into column i.
    assign nextOcc = MOVE_LEFT ? {occ[0], occ[7:1]} : {occ[6:0], occ[7]};

    always_ff @(posedge CLK_05Hz or negedge RESET) begin
        if (!RESET) begin
            cycleCnt <= '0;
            occ      <= INIT;
        end else if (state == MOVE) begin
            if (cycleCnt == LAST) begin
                cycleCnt <= '0;
                occ      <= nextOcc;    // one column per period.
            end else begin
                cycleCnt <= cycleCnt + 1'b1;
            end
        end
    end

    // vehicles neither appear nor vanish, they only wrap around.
    occCountKept : assert property (
        @(posedge CLK_05Hz) disable iff (!RESET)
        $countones(occ) == $countones(INIT)
    );

endmodule

`default_nettype wire

// ==== design/playerControl.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "frog_defines.svh"

module playerControl (
    input  wire               CLK_05Hz,
    input  wire               RESET,
    input  wire               moveReq,
    input  frogPkg::moveDir   moveDir,
    input  frogPkg::gameState state,
    output logic              moveAck,
    output logic              moveAccept,
    output frogPkg::cellCol   playerCol,
    output frogPkg::cellRow   playerRow
);
    import frogPkg::*;

    logic takeReq;
    logic upOk;
    logic leftOk;
    logic rightOk;

    // ######################################################################
    // four-phase handshake.
    // ######################################################################

    // a new request is seen only while the previous ack is down.
    assign takeReq    = moveReq && !moveAck;
    assign moveAccept = takeReq && (state == MOVE);

    always_ff @(posedge CLK_05Hz or negedge RESET) begin
        if (!RESET) begin
            moveAck <= 1'b0;
        end else if (takeReq) begin
            moveAck <= 1'b1;
        end else if (!moveReq) begin
            moveAck <= 1'b0;    // phase four.
        end
    end

    // ######################################################################
    // legality and the player cell.
    // ######################################################################

    assign upOk    = playerRow != cellRow'(0);
    assign leftOk  = playerCol != cellCol'(0);
    assign rightOk = playerCol < cellCol'(`GRID_COLS - 1);

    always_ff @(posedge CLK_05Hz or negedge RESET) begin
        if (!RESET) begin
            playerCol <= cellCol'(`START_COL);
            playerRow <= cellRow'(`START_ROW);
        end else if (moveAccept) begin
            // an illegal move still counts as a step but stays put.
            case (moveDir)
                UP: begin
                    if (upOk) playerRow <= playerRow - 1'b1;
                end
                LEFT: begin
                    if (leftOk) playerCol <= playerCol - 1'b1;
                end
                RIGHT: begin
                    if (rightOk) playerCol <= playerCol + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // the ack only ever answers a request that was already up.
    ackNeedsReq : assert property (
        @(posedge CLK_05Hz) disable iff (!RESET)
        $rose(moveAck) |-> $past(moveReq)
    );

endmodule

`default_nettype wire

// ==== design/gameJudge.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "frog_defines.svh"

module gameJudge (
    input  wire               CLK_05Hz,
    input  wire               RESET,
    input  frogPkg::cellCol   playerCol,
    input  frogPkg::cellRow   playerRow,
    input  frogPkg::laneOcc   laneCars,
    input  frogPkg::laneOcc   laneTrucks,
    input  frogPkg::laneOcc   laneBigTrucks,
    output frogPkg::gameState state
);
    import frogPkg::*;

    laneOcc rowOcc;
    logic   hit;
    logic   atGoalRow;

    // occupancy of whatever row the player stands on.
    always_comb begin
        case (playerRow)
            cellRow'(`CAR_ROW):      rowOcc = laneCars;
            cellRow'(`TRUCK_ROW):    rowOcc = laneTrucks;
            cellRow'(`BIGTRUCK_ROW): rowOcc = laneBigTrucks;
            cellRow'(0):             rowOcc = laneOcc'(`BRICK_MASK);
            default:                 rowOcc = '0;    // grass rows are safe.
        endcase
    end

    assign hit       = rowOcc[playerCol];
    assign atGoalRow = playerRow == cellRow'(0);

    always_ff @(posedge CLK_05Hz or negedge RESET) begin
        if (!RESET) begin
            state <= MOVE;
        end else if (state == MOVE) begin
            // a brick on row 0 counts as a hit, so DIE wins over SUCCESS.
            if (hit) begin
                state <= DIE;
            end else if (atGoalRow) begin
                state <= SUCCESS;
            end
        end
    end

    // once decided, the game stays decided until the next reset.
    finalHeld : assert property (
        @(posedge CLK_05Hz) disable iff (!RESET)
        (state != MOVE) |=> $stable(state)
    );

endmodule

`default_nettype wire

// ==== design/stepCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

module stepCounter (
    input  wire             CLK_05Hz,
    input  wire             RESET,
    input  wire             moveAccept,
    output frogPkg::bcdStep stepCount
);

    logic [3:0] units;
    logic [3:0] tens;

    assign units = stepCount[3:0];
    assign tens  = stepCount[7:4];

    always_ff @(posedge CLK_05Hz or negedge RESET) begin
        if (!RESET) begin
            stepCount <= 8'h00;
        end else if (moveAccept) begin
            if (units == 4'd9) begin
                // carry into tens, and 99 wraps to 00.
                if (tens == 4'd9) begin
                    stepCount <= 8'h00;
                end else begin
                    stepCount <= {tens + 4'd1, 4'd0};
                end
            end else begin
                stepCount <= {tens, units + 4'd1};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/frogTop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "frog_defines.svh"

module frogTop (
    input  wire               CLK_05Hz,
    input  wire               RESET,
    input  wire               moveReq,
    input  frogPkg::moveDir   moveDir,
    output logic              moveAck,
    output frogPkg::cellCol   playerCol,
    output frogPkg::cellRow   playerRow,
    output frogPkg::laneOcc   laneCars,
    output frogPkg::laneOcc   laneTrucks,
    output frogPkg::laneOcc   laneBigTrucks,
    output frogPkg::gameState state,
    output frogPkg::bcdStep   stepCount
);

    logic moveAccept;    // one cycle per request taken during MOVE.

    playerControl player (
        .CLK_05Hz  (CLK_05Hz),
        .RESET     (RESET),
        .moveReq   (moveReq),
        .moveDir   (moveDir),
        .state     (state),
        .moveAck   (moveAck),
        .moveAccept(moveAccept),
        .playerCol (playerCol),
        .playerRow (playerRow)
    );

    stepCounter steps (
        .CLK_05Hz  (CLK_05Hz),
        .RESET     (RESET),
        .moveAccept(moveAccept),
        .stepCount (stepCount)
    );

    gameJudge judge (
        .CLK_05Hz     (CLK_05Hz),
        .RESET        (RESET),
        .playerCol    (playerCol),
        .playerRow    (playerRow),
        .laneCars     (laneCars),
        .laneTrucks   (laneTrucks),
        .laneBigTrucks(laneBigTrucks),
        .state        (state)
    );

    // cars and trucks drive right, big trucks drive left.
    trafficLane #(.PERIOD(`CAR_PERIOD), .MOVE_LEFT(1'b0), .INIT(`CAR_INIT)) carLane (
        .CLK_05Hz(CLK_05Hz), .RESET(RESET), .state(state), .occ(laneCars)
    );
    trafficLane #(.PERIOD(`TRUCK_PERIOD), .MOVE_LEFT(1'b0), .INIT(`TRUCK_INIT)) truckLane (
        .CLK_05Hz(CLK_05Hz), .RESET(RESET), .state(state), .occ(laneTrucks)
    );
    trafficLane #(
        .PERIOD   (`BIGTRUCK_PERIOD),
        .MOVE_LEFT(1'b1),
        .INIT     (`BIGTRUCK_INIT)
    ) bigTruckLane (
        .CLK_05Hz(CLK_05Hz), .RESET(RESET), .state(state), .occ(laneBigTrucks)
    );

endmodule

`default_nettype wire

// ==== tb/tbFrogTop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "frog_defines.svh"

module tbFrogTop;
    import frogPkg::*;

    // the tests need about 1300 cycles at worst, the rest is slack.
    localparam int CYCLE_LIMIT = 3000;

    logic     CLK_05Hz;
    logic     RESET;
    logic     moveReq;
    moveDir   reqDir;
    logic     moveAck;
    cellCol   playerCol;
    cellRow   playerRow;
    laneOcc   laneCars;
    laneOcc   laneTrucks;
    laneOcc   laneBigTrucks;
    gameState state;
    bcdStep   stepCount;

    // reference model, lane index 0 is cars, 1 trucks, 2 big trucks.
    laneOcc   mLane [3];
    int       mCnt [3];
    cellCol   mCol;
    cellRow   mRow;
    gameState mState;
    logic     mAck;
    int       mSteps;
    int       seed = 35;
    int       cycles = 0;

    frogTop i_dut (.moveDir(reqDir), .*);

    always #5 CLK_05Hz = ~CLK_05Hz;

    always @(posedge CLK_05Hz) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("the run went past the limit of %0d clock cycles.", CYCLE_LIMIT);
            failRun();
        end
    end

    task automatic failRun();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    // ##########################################################################
    // compare tasks.
    // ##########################################################################

    task automatic ackBitCheck(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t moveAck got %b expected %b", $time, got, exp);
            failRun();
        end
    endtask

    task automatic compareCell(input cellCol gotCol, input cellRow gotRow,
                               input cellCol expCol, input cellRow expRow);
        if (gotCol !== expCol || gotRow !== expRow) begin
            $display("ERROR t=%0t playerCol/playerRow got (%0d,%0d) expected (%0d,%0d)",
                     $time, gotCol, gotRow, expCol, expRow);
            failRun();
        end
    endtask

    task automatic checkLane(input string name, input laneOcc got, input laneOcc exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
            failRun();
        end
    endtask

    task automatic expectState(input gameState got, input gameState exp);
        if (got !== exp) begin
            $display("ERROR t=%0t state got %s expected %s", $time, got.name(), exp.name());
            failRun();
        end
    endtask

    task automatic verifyStep(input bcdStep got, input bcdStep exp);
        if (got !== exp) begin
            $display("ERROR t=%0t stepCount got %h expected %h", $time, got, exp);
            failRun();
        end
    endtask

    // ##########################################################################
    // reference model.
    // ##########################################################################

    function automatic int lanePeriod(input int lane);
        case (lane)
            0:       return `CAR_PERIOD;
            1:       return `TRUCK_PERIOD;
            default: return `BIGTRUCK_PERIOD;
        endcase
    endfunction

    // only the big trucks drive left, toward column 0.
    function automatic laneOcc rotateLane(input int lane, input laneOcc m);
        return (lane == 2) ? {m[0], m[7:1]} : {m[6:0], m[7]};
    endfunction

    function automatic laneOcc rowOccupancy(input cellRow r);
        case (r)
            cellRow'(`CAR_ROW):      return mLane[0];
            cellRow'(`TRUCK_ROW):    return mLane[1];
            cellRow'(`BIGTRUCK_ROW): return mLane[2];
            cellRow'(0):             return laneOcc'(`BRICK_MASK);
            default:                 return '0;
        endcase
    endfunction

    function automatic bcdStep bcdOf(input int n);
        return bcdStep'(((n / 10) % 10) * 16 + n % 10);
    endfunction

    // true when the column stays free after each edge from firstEdge to lastEdge.
    function automatic bit laneClearFor(input int lane, input cellCol col,
                                        input int firstEdge, input int lastEdge);
        laneOcc m;
        int     c;
        int     e;
        bit     clear;
        m     = mLane[lane];
        c     = mCnt[lane];
        clear = 1'b1;
        for (e = 1; e <= lastEdge; e++) begin
            if (c == lanePeriod(lane) - 1) begin
                m = rotateLane(lane, m);
                c = 0;
            end else begin
                c++;
            end
            if (e >= firstEdge && m[col]) clear = 1'b0;
        end
        return clear;
    endfunction

    task automatic outputsMatchModel();
        ackBitCheck(moveAck, mAck);
        compareCell(playerCol, playerRow, mCol, mRow);
        checkLane("laneCars", laneCars, mLane[0]);
        checkLane("laneTrucks", laneTrucks, mLane[1]);
        checkLane("laneBigTrucks", laneBigTrucks, mLane[2]);
        expectState(state, mState);
        verifyStep(stepCount, bcdOf(mSteps));
    endtask

    task automatic advanceCycle();
        logic   accept;
        logic   wasMove;
        laneOcc here;
        int     i;
        @(posedge CLK_05Hz);
        @(negedge CLK_05Hz);
        // every update below starts from the values before the edge.
        wasMove = mState == MOVE;
        accept  = moveReq && !mAck && wasMove;
        here    = rowOccupancy(mRow);
        if (wasMove && here[mCol]) mState = DIE;
        else if (wasMove && mRow == 3'd0) mState = SUCCESS;
        if (moveReq && !mAck) mAck = 1'b1;
        else if (!moveReq) mAck = 1'b0;
        if (accept) begin
            case (reqDir)
                UP:      if (mRow != 3'd0) mRow = mRow - 3'd1;
                LEFT:    if (mCol != 3'd0) mCol = mCol - 3'd1;
                default: if (mCol != 3'd7) mCol = mCol + 3'd1;
            endcase
            mSteps = (mSteps + 1) % 100;    // illegal moves count too.
        end
        for (i = 0; i < 3; i++) begin
            if (wasMove && mCnt[i] == lanePeriod(i) - 1) begin
                mLane[i] = rotateLane(i, mLane[i]);
                mCnt[i]  = 0;
            end else if (wasMove) begin
                mCnt[i]++;
            end
        end
        outputsMatchModel();
    endtask

    // ##########################################################################
    // stimulus helpers.
    // ##########################################################################

    task automatic idleCycles(input int n);
        repeat (n) advanceCycle();
    endtask

    task automatic randomGap();
        idleCycles(($random(seed) & 3) + 1);
    endtask

    task automatic applyReset();
        RESET   = 1'b0;
        moveReq = 1'b0;
        repeat (5) @(negedge CLK_05Hz);
        mLane[0] = `CAR_INIT;
        mLane[1] = `TRUCK_INIT;
        mLane[2] = `BIGTRUCK_INIT;
        mCnt     = '{0, 0, 0};
        mCol     = cellCol'(`START_COL);
        mRow     = cellRow'(`START_ROW);
        mState   = MOVE;
        mAck     = 1'b0;
        mSteps   = 0;
        RESET    = 1'b1;
        outputsMatchModel();
    endtask

    // one full four-phase request, two edges when the DUT answers at once.
    task automatic requestMove(input moveDir d);
        int waited;
        moveReq = 1'b1;
        reqDir  = d;
        waited  = 0;
        while (moveAck !== 1'b1) begin
            if (waited == 4) begin
                $display("moveAck never rose for a pending request.");
                failRun();
            end else begin
                advanceCycle();
                waited++;
            end
        end
        moveReq = 1'b0;
        waited  = 0;
        while (moveAck !== 1'b0) begin
            if (waited == 4) begin
                $display("moveAck stayed high after moveReq was dropped.");
                failRun();
            end else begin
                advanceCycle();
                waited++;
            end
        end
    endtask

    // second < 0 means that only one lane is crossed.
    task automatic holdUntilClear(input int first, input int second);
        int waited;
        waited = 0;
        while (!(laneClearFor(first, mCol, 1, 2) &&
                 (second < 0 || laneClearFor(second, mCol, 3, 4)))) begin
            if (waited == 200) begin
                $display("no gap in the traffic came along for the crossing.");
                failRun();
            end else begin
                advanceCycle();
                waited++;
            end
        end
    endtask

    task automatic crossToRow0(input cellCol target, input gameState finalState);
        while (mCol != target) begin
            if (mCol < target) requestMove(RIGHT);
            else requestMove(LEFT);
            randomGap();
        end
        holdUntilClear(0, 1);
        requestMove(UP);
        requestMove(UP);
        requestMove(UP);    // now on the grass of row 2.
        randomGap();
        holdUntilClear(2, -1);
        requestMove(UP);
        requestMove(UP);
        idleCycles(2);
        expectState(state, finalState);
    endtask

    // ##########################################################################
    // directed tests.
    // ##########################################################################

    task automatic resetValues();
        applyReset();
        ackBitCheck(moveAck, 1'b0);
        compareCell(playerCol, playerRow, cellCol'(`START_COL), cellRow'(`START_ROW));
        checkLane("laneCars", laneCars, `CAR_INIT);
        checkLane("laneTrucks", laneTrucks, `TRUCK_INIT);
        checkLane("laneBigTrucks", laneBigTrucks, `BIGTRUCK_INIT);
        expectState(state, MOVE);
        verifyStep(stepCount, 8'h00);
    endtask

    task automatic laneMotion();
        idleCycles(40);
    endtask

    task automatic movesAndLimits();
        requestMove(LEFT);
        compareCell(playerCol, playerRow, 3'd0, 3'd5);
        randomGap();
        requestMove(LEFT);
        compareCell(playerCol, playerRow, 3'd0, 3'd5);
        verifyStep(stepCount, 8'h02);
        randomGap();
        requestMove(RIGHT);
        compareCell(playerCol, playerRow, 3'd1, 3'd5);
    endtask

    task automatic bcdCarry();
        repeat (6) begin
            requestMove(RIGHT);
            randomGap();
            requestMove(LEFT);
            randomGap();
        end
        verifyStep(stepCount, 8'h15);
    endtask

    task automatic deathByCar();
        laneOcc carsNow;
        laneOcc trucksNow;
        laneOcc bigNow;
        cellCol colNow;
        cellRow rowNow;
        bcdStep stepNow;
        int     waited;
        waited = 0;
        while (!(mCnt[0] == `CAR_PERIOD - 1 && !laneClearFor(0, mCol, 1, 1))) begin
            if (waited == 64) begin
                $display("no car ever headed for the player's column.");
                failRun();
            end else begin
                advanceCycle();
                waited++;
            end
        end
        requestMove(UP);
        idleCycles(1);
        expectState(state, DIE);
        carsNow   = mLane[0];
        trucksNow = mLane[1];
        bigNow    = mLane[2];
        idleCycles(12);
        checkLane("laneCars", laneCars, carsNow);
        checkLane("laneTrucks", laneTrucks, trucksNow);
        checkLane("laneBigTrucks", laneBigTrucks, bigNow);
        colNow  = mCol;
        rowNow  = mRow;
        stepNow = bcdOf(mSteps);
        requestMove(LEFT);    // acknowledged, but the game is over.
        compareCell(playerCol, playerRow, colNow, rowNow);
        verifyStep(stepCount, stepNow);
    endtask

    task automatic successAndBrick();
        applyReset();
        crossToRow0(3'd4, SUCCESS);
        applyReset();
        crossToRow0(3'd3, DIE);
    endtask

    initial begin
        CLK_05Hz = 1'b0;
        RESET    = 1'b0;
        moveReq  = 1'b0;
        reqDir   = UP;
        resetValues();
        laneMotion();
        movesAndLimits();
        bcdCarry();
        deathByCar();
        successAndBrick();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/frogPkg.sv
design/trafficLane.sv
design/playerControl.sv
design/gameJudge.sv
design/stepCounter.sv
design/frogTop.sv
tb/tbFrogTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the frogTop testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tbFrogTop

output=$(./obj_dir/VtbFrogTop 2>&1) || true
echo "$output"

if grep -Fqx ">>> PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
